/* run_sim.sh */
#!/bin/sh
# Build tb_rx_top with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_rx_top -f src.f -o tb_rx_top \
    && ./obj_dir/tb_rx_top 2>&1 | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

/* rx_frame_writer.sv */
`timescale 1ns/1ps

module rx_frame_writer #(
    parameter int BUF_AW = rx_pkg::BUF_AW_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rx_pkg::qw_t       mac_rx_data,
    input  logic [7:0]        mac_rx_data_valid,
    input  logic              mac_rx_good_frame,
    input  logic              mac_rx_bad_frame,
    input  logic [BUF_AW:0]   committed_cons,
    output logic              wr_en,
    output logic [BUF_AW-1:0] wr_addr,
    output rx_pkg::qw_t       wr_data,
    output logic [BUF_AW:0]   committed_prod,
    output logic [15:0]       dropped_pkts
);
    import rx_pkg::*;

    logic              in_frame;                     // Between first beat and end strobe
    logic              drop;                         // Current frame hit the consumer
    logic [BUF_AW:0]   wr_ptr;                       // Next free slot
    logic [BUF_AW:0]   len_ptr;                      // Reserved length slot
    logic [15:0]       byte_cnt;
    logic [3:0]        beat_bytes;
    logic              beat;
    logic [BUF_AW:0]   data_ptr;
    logic [BUF_AW:0]   fill;
    logic              ovf;
    logic              accept;
    logic              commit_len;

    // ----------------------------------------
    // Beat decode
    // ----------------------------------------
    assign beat     = |mac_rx_data_valid;            // Any byte lane valid
    assign data_ptr = in_frame ? wr_ptr : wr_ptr + 1'b1;   // Skip length slot on first beat
    assign fill     = data_ptr - committed_cons;
    assign ovf      = fill[BUF_AW];                  // Slot would land on unread data
    assign accept   = beat && !drop && !ovf;

    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < QW_BYTES; i++) begin
            beat_bytes = beat_bytes + 4'(mac_rx_data_valid[i]);   // Popcount of mask
        end
    end

    // ----------------------------------------
    // Ring write port
    // ----------------------------------------
    assign commit_len = mac_rx_good_frame && in_frame && !drop;
    assign wr_en      = commit_len || accept;
    assign wr_addr    = commit_len ? len_ptr[BUF_AW-1:0] : data_ptr[BUF_AW-1:0];
    assign wr_data    = commit_len ? qw_t'(byte_cnt) : mac_rx_data;   // Length word is zero-extended

    // Frame state and pointers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_frame       <= 1'b0;
            drop           <= 1'b0;
            wr_ptr         <= '0;
            committed_prod <= '0;
            dropped_pkts   <= '0;
        end else if (mac_rx_good_frame && in_frame) begin
            in_frame <= 1'b0;
            drop     <= 1'b0;
            if (drop) begin
                dropped_pkts <= dropped_pkts + 1'b1;
                wr_ptr       <= committed_prod;      // Discard partial frame
            end else begin
                committed_prod <= wr_ptr;            // Publish whole frame
            end
        end else if (mac_rx_bad_frame && in_frame) begin
            in_frame <= 1'b0;
            drop     <= 1'b0;
            wr_ptr   <= committed_prod;              // Rewind, not counted
        end else if (beat) begin
            in_frame <= 1'b1;
            if (accept) begin
                wr_ptr <= data_ptr + 1'b1;
            end else begin
                drop <= 1'b1;                        // Ignore rest of frame
            end
        end
    end

    // Length slot and byte counter
    always_ff @(posedge clk) begin
        if (beat && !in_frame) begin
            len_ptr  <= wr_ptr;
            byte_cnt <= 16'(beat_bytes);
        end else if (beat) begin
            byte_cnt <= byte_cnt + 16'(beat_bytes);
        end
    end

endmodule

/* rx_pkg.sv */
package rx_pkg;

    // ----------------------------------------
    // Ring storage
    // ----------------------------------------
    typedef logic [63:0] qw_t;                       // One ring slot / one TRN beat

    localparam int QW_BYTES       = 8;               // Bytes per quad-word
    localparam int BUF_AW_DEFAULT = 9;               // 512 quad-words

    // ----------------------------------------
    // Packet sizing
    // ----------------------------------------
    localparam int MAX_QW_CAP = 32;                  // Largest payload, fits 6-bit qw_cnt

    // Format/type byte for a 4DW memory write with data
    localparam logic [7:0] TLP_FMT_MWR64 = 8'h60;

    // Max payload code to quad-words
    // Code 0 is 128 bytes, everything larger is capped at 256 bytes
    function automatic logic [5:0] max_payload_qw(input logic [2:0] code);
        logic [5:0] qws;
        if (code == 3'd0) begin
            qws = 6'd16;                             // 128 B
        end else begin
            qws = 6'(MAX_QW_CAP);                    // 256 B and up
        end
        return qws;
    endfunction

endpackage

/* rx_ring_buf.sv */
`timescale 1ns/1ps

module rx_ring_buf #(
    parameter int BUF_AW = rx_pkg::BUF_AW_DEFAULT
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [BUF_AW-1:0] wr_addr,
    input  rx_pkg::qw_t       wr_data,
    input  logic [BUF_AW-1:0] rd_addr,
    output rx_pkg::qw_t       rd_data
);
    import rx_pkg::*;

    localparam int DEPTH = 1 << BUF_AW;

    qw_t mem [DEPTH];                                // Quad-word ring storage

    // Write side from the frame writer
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rx_tlp_builder.sv */
`timescale 1ns/1ps

module rx_tlp_builder #(
    parameter int BUF_AW = rx_pkg::BUF_AW_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              send_qws,
    input  logic [5:0]        qw_cnt,
    input  logic [15:0]       cfg_completer_id,
    input  logic [63:0]       host_buf_addr,
    input  rx_pkg::qw_t       rd_data,
    input  logic              trn_tdst_rdy_n,
    input  logic [3:0]        trn_tbuf_av,
    output logic              send_qws_ack,
    output logic [BUF_AW:0]   committed_cons,
    output logic [BUF_AW-1:0] rd_addr,
    output logic [63:0]       trn_td,
    output logic [7:0]        trn_trem_n,
    output logic              trn_tsof_n,
    output logic              trn_teof_n,
    output logic              trn_tsrc_rdy_n
);
    import rx_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR0,
        S_HDR1,
        S_DATA
    } state_t;

    state_t            state;                        // Names the next beat to load
    logic [5:0]        cnt_r;                        // Latched packet size
    logic [5:0]        rem;                          // Data beats still to load
    logic [BUF_AW-1:0] rd_ptr;                       // Ring word for the next data beat
    logic              xfer;
    logic              out_free;
    logic              load_hdr0;
    logic              load_hdr1;
    logic              load_data;
    logic              last_xfer;
    qw_t               hdr0;
    qw_t               hdr1;

    // ----------------------------------------
    // Handshake and load strobes
    // ----------------------------------------
    assign xfer      = !trn_tsrc_rdy_n && !trn_tdst_rdy_n;
    assign out_free  = trn_tsrc_rdy_n || !trn_tdst_rdy_n;   // Empty or draining
    assign load_hdr0 = (state == S_HDR0) && out_free && (|trn_tbuf_av);
    assign load_hdr1 = (state == S_HDR1) && out_free;
    assign load_data = (state == S_DATA) && out_free;
    assign last_xfer = xfer && !trn_teof_n;

    // Prefetch keeps rd_data equal to the word at rd_ptr
    assign rd_addr    = rd_ptr + BUF_AW'(load_data);
    assign trn_trem_n = '0;                          // Every beat is full

    // Header beats
    assign hdr0 = {TLP_FMT_MWR64, 8'h00, cfg_completer_id, 22'd0, 3'd0, cnt_r, 1'b0};
    assign hdr1 = host_buf_addr + 64'(committed_cons[BUF_AW-1:0]) * QW_BYTES;

    // ----------------------------------------
    // FSM and framing strobes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            rem            <= '0;
            rd_ptr         <= '0;
            committed_cons <= '0;
            send_qws_ack   <= 1'b0;
            trn_tsrc_rdy_n <= 1'b1;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
        end else begin
            send_qws_ack <= last_xfer;
            if (last_xfer) begin
                committed_cons <= committed_cons + (BUF_AW + 1)'(cnt_r);   // Free sent slots
            end
            if (xfer) begin
                trn_tsrc_rdy_n <= 1'b1;              // Empty unless reloaded below
                trn_tsof_n     <= 1'b1;
                trn_teof_n     <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (send_qws) begin
                        state <= S_HDR0;
                    end
                end
                S_HDR0: begin
                    if (load_hdr0) begin
                        trn_tsrc_rdy_n <= 1'b0;
                        trn_tsof_n     <= 1'b0;
                        state          <= S_HDR1;
                    end
                end
                S_HDR1: begin
                    if (load_hdr1) begin
                        trn_tsrc_rdy_n <= 1'b0;
                        rem            <= cnt_r;
                        state          <= S_DATA;
                    end
                end
                default: begin
                    if (load_data) begin
                        trn_tsrc_rdy_n <= 1'b0;
                        rem            <= rem - 1'b1;
                        rd_ptr         <= rd_ptr + 1'b1;
                        if (rem == 6'd1) begin
                            trn_teof_n <= 1'b0;      // Last data beat
                            state      <= S_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Beat payload, held while stalled
    always_ff @(posedge clk) begin
        if (state == S_IDLE && send_qws) begin
            cnt_r <= qw_cnt;
        end
        if (load_hdr0) begin
            trn_td <= hdr0;
        end else if (load_hdr1) begin
            trn_td <= hdr1;
        end else if (load_data) begin
            trn_td <= rd_data;
        end
    end

endmodule

/* rx_tlp_ctrl.sv */
`timescale 1ns/1ps

module rx_tlp_ctrl #(
    parameter int BUF_AW = rx_pkg::BUF_AW_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [2:0]      cfg_max_payload_size,
    input  logic            host_buf_en,
    input  logic [BUF_AW:0] committed_prod,
    input  logic [BUF_AW:0] committed_cons,
    input  logic            send_qws_ack,
    output logic            send_qws,
    output logic [5:0]      qw_cnt
);
    import rx_pkg::*;

    localparam int CNT_W = $clog2(MAX_QW_CAP + 1);   // 6 bits for 32

    logic [BUF_AW:0]  occ;                           // Committed, not yet sent
    logic [CNT_W-1:0] lim;
    logic             occ_nz_r;
    logic [CNT_W-1:0] chunk_r;
    logic             busy;                          // Packet in flight

    assign occ = committed_prod - committed_cons;
    assign lim = max_payload_qw(cfg_max_payload_size);

    // ----------------------------------------
    // Stage 1 sizes the chunk
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ_nz_r <= 1'b0;
        end else begin
            occ_nz_r <= |occ;
        end
    end

    always_ff @(posedge clk) begin
        chunk_r <= (occ > lim) ? lim : CNT_W'(occ);  // min(occupancy, payload limit)
    end

    // ----------------------------------------
    // Stage 2 issues the request
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            send_qws <= 1'b0;
            busy     <= 1'b0;
        end else begin
            send_qws <= 1'b0;                        // Single-cycle pulse
            if (send_qws_ack) begin
                busy <= 1'b0;
            end else if (occ_nz_r && host_buf_en && !busy) begin
                send_qws <= 1'b1;
                busy     <= 1'b1;
            end
        end
    end

    // Size held stable until the next request
    always_ff @(posedge clk) begin
        if (occ_nz_r && host_buf_en && !busy && !send_qws_ack) begin
            qw_cnt <= chunk_r;
        end
    end

endmodule

/* rx_top.sv */
`timescale 1ns/1ps

module rx_top #(
    parameter int BUF_AW = rx_pkg::BUF_AW_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    // MAC receive
    input  rx_pkg::qw_t mac_rx_data,
    input  logic [7:0]  mac_rx_data_valid,
    input  logic        mac_rx_good_frame,
    input  logic        mac_rx_bad_frame,
    // Config and host buffer
    input  logic [2:0]  cfg_max_payload_size,
    input  logic [15:0] cfg_completer_id,
    input  logic [63:0] host_buf_addr,
    input  logic        host_buf_en,
    // TRN transmit
    output logic [63:0] trn_td,
    output logic [7:0]  trn_trem_n,
    output logic        trn_tsof_n,
    output logic        trn_teof_n,
    output logic        trn_tsrc_rdy_n,
    input  logic        trn_tdst_rdy_n,
    input  logic [3:0]  trn_tbuf_av,
    // Stats
    output logic [15:0] dropped_pkts
);
    import rx_pkg::*;

    // ----------------------------------------
    // Ring ports
    // ----------------------------------------
    logic              wr_en;
    logic [BUF_AW-1:0] wr_addr;
    qw_t               wr_data;
    logic [BUF_AW-1:0] rd_addr;
    qw_t               rd_data;

    // ----------------------------------------
    // Pointers and request handshake
    // ----------------------------------------
    logic [BUF_AW:0]   committed_prod;
    logic [BUF_AW:0]   committed_cons;
    logic              send_qws;
    logic              send_qws_ack;
    logic [5:0]        qw_cnt;

    rx_frame_writer #(.BUF_AW(BUF_AW)) u_writer (
        .clk               (clk),
        .rst_n             (rst_n),
        .mac_rx_data       (mac_rx_data),
        .mac_rx_data_valid (mac_rx_data_valid),
        .mac_rx_good_frame (mac_rx_good_frame),
        .mac_rx_bad_frame  (mac_rx_bad_frame),
        .committed_cons    (committed_cons),     // Space check
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .committed_prod    (committed_prod),
        .dropped_pkts      (dropped_pkts)
    );

    rx_ring_buf #(.BUF_AW(BUF_AW)) u_ring (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    rx_tlp_ctrl #(.BUF_AW(BUF_AW)) u_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .cfg_max_payload_size (cfg_max_payload_size),
        .host_buf_en          (host_buf_en),
        .committed_prod       (committed_prod),
        .committed_cons       (committed_cons),
        .send_qws_ack         (send_qws_ack),
        .send_qws             (send_qws),
        .qw_cnt               (qw_cnt)
    );

    rx_tlp_builder #(.BUF_AW(BUF_AW)) u_builder (
        .clk              (clk),
        .rst_n            (rst_n),
        .send_qws         (send_qws),
        .qw_cnt           (qw_cnt),
        .cfg_completer_id (cfg_completer_id),
        .host_buf_addr    (host_buf_addr),
        .rd_data          (rd_data),
        .trn_tdst_rdy_n   (trn_tdst_rdy_n),
        .trn_tbuf_av      (trn_tbuf_av),
        .send_qws_ack     (send_qws_ack),
        .committed_cons   (committed_cons),
        .rd_addr          (rd_addr),
        .trn_td           (trn_td),
        .trn_trem_n       (trn_trem_n),
        .trn_tsof_n       (trn_tsof_n),
        .trn_teof_n       (trn_teof_n),
        .trn_tsrc_rdy_n   (trn_tsrc_rdy_n)
    );

endmodule

/* rx_top_sva.sv */
`timescale 1ns/1ps

module rx_top_sva (
    input logic        clk,
    input logic        rst_n,
    input logic [63:0] trn_td,
    input logic        trn_tsof_n,
    input logic        trn_teof_n,
    input logic        trn_tsrc_rdy_n,
    input logic        trn_tdst_rdy_n,
    input logic        send_qws,
    input logic        send_qws_ack
);

    logic pending;                                         // Request seen, ack not yet
    int   fail_cnt = 0;                                    // Failed assertions so far

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (send_qws) begin
            pending <= 1'b1;
        end else if (send_qws_ack) begin
            pending <= 1'b0;
        end
    end

    // Framing strobes only with a valid beat
    a_strobe_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (!trn_tsof_n || !trn_teof_n) |-> !trn_tsrc_rdy_n)
        else begin
            $error("sof or eof strobe without source ready");
            fail_cnt++;
        end

    // Stalled beat is held
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!trn_tsrc_rdy_n && trn_tdst_rdy_n) |=> (!trn_tsrc_rdy_n && $stable(trn_td)))
        else begin
            $error("beat changed while stalled");
            fail_cnt++;
        end

    a_ack_pending: assert property (@(posedge clk) disable iff (!rst_n)
        send_qws_ack |-> pending)
        else begin
            $error("send_qws_ack without an outstanding send_qws");
            fail_cnt++;
        end

endmodule

bind rx_top rx_top_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .trn_td         (trn_td),
    .trn_tsof_n     (trn_tsof_n),
    .trn_teof_n     (trn_teof_n),
    .trn_tsrc_rdy_n (trn_tsrc_rdy_n),
    .trn_tdst_rdy_n (trn_tdst_rdy_n),
    .send_qws       (send_qws),
    .send_qws_ack   (send_qws_ack)
);

/* src.f */
rx_pkg.sv
rx_ring_buf.sv
rx_frame_writer.sv
rx_tlp_ctrl.sv
rx_tlp_builder.sv
rx_top.sv
rx_top_sva.sv
tb_rx_top.sv

/* tb_rx_top.sv */
`timescale 1ns/1ps

module tb_rx_top;
    import rx_pkg::*;

    localparam int BUF_AW     = 6;
    localparam int RING_QWS   = 1 << BUF_AW;               // 64-word ring
    localparam int MAX_CYCLES = 20000;                     // About 4x the longest test
    localparam logic [63:0] HDR0_MASK = 64'hFF00_FFFF_0000_03FF;   // Fmt, requester ID, length

    logic        clk;
    logic        rst_n;
    qw_t         mac_rx_data;
    logic [7:0]  mac_rx_data_valid;
    logic        mac_rx_good_frame;
    logic        mac_rx_bad_frame;
    logic [2:0]  cfg_max_payload_size;
    logic [15:0] cfg_completer_id;
    logic [63:0] host_buf_addr;
    logic        host_buf_en;
    logic [63:0] trn_td;
    logic [7:0]  trn_trem_n;
    logic        trn_tsof_n;
    logic        trn_teof_n;
    logic        trn_tsrc_rdy_n;
    logic        trn_tdst_rdy_n;
    logic [3:0]  trn_tbuf_av;
    logic [15:0] dropped_pkts;

    qw_t         exp_q[$];                                 // Ring model, oldest first
    int          size_log[$];                              // Payload size per packet
    logic [63:0] addr_log[$];                              // Host address per packet
    int          pushed_total;                             // Words committed by the model
    int          cons_total;                               // Words freed by sent packets
    int          exp_drops;
    int          beat_idx;                                 // Position in current packet
    int          pkt_qws;
    int          pkt_cnt;
    int          beat_cnt;
    int          chk_cnt;
    int          err_cnt;
    int          cycles;
    logic        bp_en;                                    // Random back-pressure on

    rx_top #(.BUF_AW(BUF_AW)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                             // 8 ns period
    end

    // ----------------------------------------
    // Reference rules
    // ----------------------------------------
    function automatic int mask_bytes(input logic [7:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            n += int'(mask[i]);
        end
        return n;
    endfunction

    function automatic int payload_limit(input logic [2:0] code);
        return (code == 3'd0) ? 16 : 32;                   // 128 B, else 256 B
    endfunction

    function automatic logic [63:0] hdr0_ref(input logic [15:0] id, input int qws);
        return {TLP_FMT_MWR64, 8'h00, id, 22'd0, 10'(2 * qws)};   // Length in dwords
    endfunction

    function automatic logic [63:0] addr_ref(input logic [63:0] base, input int idx);
        return base + 64'((idx % RING_QWS) * 8);
    endfunction

    task automatic compare_val(input string sig, input logic [63:0] got,
                               input logic [63:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            $display("Fail %0t %s: got %h expected %h", $time, sig, got, exp);
            err_cnt++;
        end
    endtask

    task automatic flag_error(input string what);
        $display("Error at %0t: %s", $time, what);
        err_cnt++;
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic drive_frame(input int beats, input logic [7:0] last_mask,
                               input bit good, input bit rnd_mask);
        qw_t        words[$];
        qw_t        data;
        logic [7:0] mask;
        int         bytes;
        bit         fits;
        fits  = (pushed_total - cons_total + beats + 1 <= RING_QWS);   // Length slot too
        bytes = 0;
        for (int i = 0; i < beats; i++) begin
            data = {$urandom, $urandom};
            mask = (i == beats - 1) ? last_mask : 8'hFF;
            if (rnd_mask) begin
                mask = 8'($urandom);
                if (mask == 8'h00) begin
                    mask = 8'h80;                          // Keep it a beat
                end
            end
            @(posedge clk);
            mac_rx_data       <= data;
            mac_rx_data_valid <= mask;
            words.push_back(data);
            bytes += mask_bytes(mask);
        end
        @(posedge clk);
        mac_rx_data_valid <= 8'h00;
        mac_rx_good_frame <= good;                         // End strobe after last beat
        mac_rx_bad_frame  <= !good;
        if (good && fits) begin
            exp_q.push_back(qw_t'(16'(bytes)));            // Length word first
            foreach (words[i]) begin
                exp_q.push_back(words[i]);
            end
            pushed_total += beats + 1;
        end else if (good) begin
            exp_drops++;
        end
        @(posedge clk);
        mac_rx_good_frame <= 1'b0;
        mac_rx_bad_frame  <= 1'b0;
    endtask

    task automatic wait_room(input int beats);
        while (pushed_total - cons_total + beats + 1 > RING_QWS) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        while (pushed_total != cons_total || beat_idx != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        $display("Test %0d %s: %0d errors", num, name, err_cnt - errs_before);
    endtask

    // ----------------------------------------
    // TRN monitor and comparison
    // ----------------------------------------
    always @(posedge clk) begin
        if (bp_en) begin
            trn_tdst_rdy_n <= (($urandom % 100) < 40);     // Stall about 40% of cycles
        end else begin
            trn_tdst_rdy_n <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst_n && !trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
            beat_cnt++;
            compare_val("trn_trem_n", trn_trem_n, 64'd0);
            compare_val("trn_tsof_n", trn_tsof_n, (beat_idx == 0) ? 64'd0 : 64'd1);
            if (beat_idx == 0) begin
                pkt_qws = int'(trn_td[9:1]);
                compare_val("trn_td header 0", trn_td & HDR0_MASK,
                            hdr0_ref(cfg_completer_id, pkt_qws));
                chk_cnt++;
                assert (pkt_qws >= 1 && pkt_qws <= payload_limit(cfg_max_payload_size)
                        && pkt_qws <= pushed_total - cons_total)
                    else flag_error("packet size outside payload limit or ring occupancy");
            end else if (beat_idx == 1) begin
                compare_val("trn_td address", trn_td, addr_ref(host_buf_addr, cons_total));
                addr_log.push_back(trn_td);
            end else begin
                chk_cnt++;
                assert (exp_q.size() > 0) else flag_error("data beat with no stored word left");
                if (exp_q.size() > 0) begin
                    compare_val("trn_td data", trn_td, exp_q.pop_front());
                end
            end
            compare_val("trn_teof_n", trn_teof_n, (beat_idx == pkt_qws + 1) ? 64'd0 : 64'd1);
            if (!trn_teof_n) begin
                cons_total += pkt_qws;                     // Ring slots freed
                size_log.push_back(pkt_qws);
                pkt_cnt++;
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the ring never drained", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int e0;
        int p0;
        int s0;
        int b0;
        int n;
        void'($urandom(13882));
        {pushed_total, cons_total, exp_drops, beat_idx, pkt_qws} = '0;
        {pkt_cnt, beat_cnt, chk_cnt, err_cnt} = '0;
        rst_n                <= 1'b0;
        bp_en                <= 1'b0;
        mac_rx_data          <= '0;
        mac_rx_data_valid    <= 8'h00;
        mac_rx_good_frame    <= 1'b0;
        mac_rx_bad_frame     <= 1'b0;
        cfg_max_payload_size <= 3'd1;
        cfg_completer_id     <= 16'h0108;
        host_buf_addr        <= 64'h0000_0001_2345_6000;
        host_buf_en          <= 1'b1;
        trn_tdst_rdy_n       <= 1'b0;
        trn_tbuf_av          <= 4'd4;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // One frame, 32 + 4 bytes
        e0 = err_cnt;
        p0 = pkt_cnt;
        drive_frame(5, 8'h0F, 1'b1, 1'b0);
        wait_drain();
        compare_val("packet count", 64'(pkt_cnt - p0), 64'd1);
        compare_val("packet size", 64'(size_log[$]), 64'd6);
        compare_val("packet address", addr_log[$], host_buf_addr);
        end_test(1, "single frame", e0);

        // Bad frame is rewound, not dropped
        e0 = err_cnt;
        p0 = pkt_cnt;
        drive_frame(4, 8'hFF, 1'b0, 1'b1);
        drive_frame(3, 8'h3C, 1'b1, 1'b0);
        wait_drain();
        compare_val("dropped_pkts", 64'(dropped_pkts), 64'(exp_drops));
        compare_val("packet count", 64'(pkt_cnt - p0), 64'd1);
        compare_val("packet size", 64'(size_log[$]), 64'd4);
        end_test(2, "bad then good frame", e0);

        // 41 words at 16 per packet
        e0 = err_cnt;
        p0 = pkt_cnt;
        s0 = size_log.size();
        @(posedge clk);
        cfg_max_payload_size <= 3'd0;
        drive_frame(40, 8'hFF, 1'b1, 1'b0);
        wait_drain();
        compare_val("packet count", 64'(pkt_cnt - p0), 64'd3);
        compare_val("packet size", 64'(size_log[s0]), 64'd16);
        compare_val("packet size", 64'(size_log[s0 + 1]), 64'd16);
        compare_val("packet size", 64'(size_log[s0 + 2]), 64'd9);
        compare_val("address step", addr_log[s0 + 1] - addr_log[s0], 64'd128);
        compare_val("address step", addr_log[s0 + 2] - addr_log[s0 + 1], 64'd128);
        cfg_max_payload_size <= 3'd1;
        end_test(3, "payload split", e0);

        // Random frames under back-pressure
        e0 = err_cnt;
        bp_en <= 1'b1;
        for (int f = 0; f < 30; f++) begin
            n = 1 + ($urandom % 8);
            wait_room(n);
            drive_frame(n, 8'hFF, 1'b1, 1'b1);
            repeat ($urandom % 3) @(posedge clk);          // Uneven gaps
        end
        wait_drain();
        bp_en <= 1'b0;
        compare_val("dropped_pkts", 64'(dropped_pkts), 64'(exp_drops));
        compare_val("model words left", 64'(exp_q.size()), 64'd0);
        end_test(4, "back-pressure", e0);

        // Fill with the host side off, 8 words per frame
        e0 = err_cnt;
        p0 = pkt_cnt;
        b0 = beat_cnt;
        @(posedge clk);
        host_buf_en <= 1'b0;
        for (int f = 0; f < 10; f++) begin
            drive_frame(7, 8'hFF, 1'b1, 1'b0);
        end
        repeat (20) @(posedge clk);
        compare_val("beats while disabled", 64'(beat_cnt - b0), 64'd0);
        compare_val("dropped_pkts", 64'(dropped_pkts), 64'(exp_drops));
        host_buf_en <= 1'b1;
        wait_drain();
        compare_val("packet count", 64'(pkt_cnt - p0), 64'd2);
        compare_val("model words left", 64'(exp_q.size()), 64'd0);
        end_test(5, "ring overflow", e0);

        $display("Summary: %0d checks, %0d failed, %0d SVA failures, %0d packets, %0d beats",
                 chk_cnt, err_cnt, DUT.u_sva.fail_cnt, pkt_cnt, beat_cnt);
        if (err_cnt == 0 && DUT.u_sva.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
